/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_avr_core
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	$(SIM_BIN) | tee $(LOG)
	@grep -qF '*** PASSED ***' $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* src.f */
+incdir+verilog
verilog/avr_pkg.sv
verilog/program_memory.sv
verilog/register_file.sv
verilog/alu.sv
verilog/return_stack.sv
verilog/control_unit.sv
verilog/avr_core.sv
test/tb_avr_core.sv

/* test/avr_stim.txt */
# program: word count, then one instruction word per line from address 0, all hex
# trace: pc wb_en rd value flags(z n c v bits) next_pc, all hex
1d
e70f  # ldi r16, 0x7f
e011  # ldi r17, 0x01
0f01  # add r16, r17 signed overflow
ef2f
0f21  # add r18, r17 carry out
1b00  # sub r16, r16 zero
e03f
1b13  # sub r17, r19 borrow
2313
2733
2e01  # mov r0, r17
c002  # rjmp forward
e505
e505
d005  # rcall 0x14
c00c
ecf3
0000
e505
e505
e55a
d003  # nested rcall 0x19
9508
e505
e505
2e15
9508
e505
cff3  # rjmp back to 0x10
00 1 10 7f 0 01
01 1 11 01 0 02
02 1 10 80 5 03
03 1 12 ff 5 04
04 1 12 00 a 05
05 1 10 00 8 06
06 1 13 0f 8 07
07 1 11 f2 6 08
08 1 11 02 2 09
09 1 13 00 a 0a
0a 1 00 02 a 0b
0b 0 00 00 a 0e
0e 0 00 00 a 14
14 1 15 5a a 15
15 0 00 00 a 19
19 1 01 5a a 1a
1a 0 00 00 a 16
16 0 00 00 a 0f
0f 0 00 00 a 1c
1c 0 00 00 a 10
10 1 1f c3 a 11
11 0 00 00 a 12

/* test/tb_avr_core.sv */
`timescale 1ns/1ps
`include "avr_macros.svh"

module tb_avr_core;

    localparam int RETIRE_TIMEOUT = 20;
    localparam int NEWLINE = 10;

    logic            clk = 1'b0;
    logic            rst_n;
    logic            run;
    logic            prog_we;
    avr_pkg::pc_t    prog_addr;
    avr_pkg::instr_t prog_data;
    logic            retire_valid;
    avr_pkg::trace_t retire_trace;

    int              stim_fd;
    avr_pkg::instr_t program_q[$];
    avr_pkg::trace_t expect_q[$];

    avr_core avr_core_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .run          (run),
        .prog_we      (prog_we),
        .prog_addr    (prog_addr),
        .prog_data    (prog_data),
        .retire_valid (retire_valid),
        .retire_trace (retire_trace)
    );

    always #5 clk = ~clk;

    task automatic abort_run();
        $display("*** FAILED ***");
        $fatal(1, "simulation stopped at %0t", $time);
    endtask

    // reads the next hex field and skips '#' comments up to the end of their line
    task automatic read_hex(output logic [31:0] value, output bit got);
        int code;
        int ch;
        bit done;
        got = 1'b0;
        done = 1'b0;
        value = '0;
        while (!done)
        begin
            code = $fscanf(stim_fd, "%h", value);
            if (code == 1)
            begin
                got = 1'b1;
                done = 1'b1;
            end
            else if (code < 0)
                done = 1'b1;
            else
            begin
                ch = $fgetc(stim_fd);
                while (ch != NEWLINE && ch != -1)
                    ch = $fgetc(stim_fd);
                if (ch == -1)
                    done = 1'b1;
            end
        end
    endtask

    task automatic load_stimulus();
        logic [31:0]     count;
        logic [31:0]     f [6];
        bit              got;
        bit              more;
        avr_pkg::trace_t rec;
        stim_fd = $fopen("test/avr_stim.txt", "r");
        if (stim_fd == 0)
        begin
            $display("cannot open the stimulus file test/avr_stim.txt");
            abort_run();
        end
        read_hex(count, got);
        if (!got)
        begin
            $display("stimulus file has no program word count");
            abort_run();
        end
        for (int i = 0; i < int'(count); i++)
        begin
            read_hex(f[0], got);
            if (!got)
            begin
                $display("stimulus file ends inside the program words");
                abort_run();
            end
            program_q.push_back(avr_pkg::instr_t'(f[0]));
        end
        more = 1'b1;
        while (more)
        begin
            read_hex(f[0], got);
            if (!got)
                more = 1'b0;
            else
            begin
                for (int k = 1; k < 6; k++)
                begin
                    read_hex(f[k], got);
                    if (!got)
                    begin
                        $display("trace record %0d in the stimulus file is incomplete",
                                 expect_q.size());
                        abort_run();
                    end
                end
                rec.pc       = avr_pkg::pc_t'(f[0]);
                rec.wb_en    = f[1][0];
                rec.rd       = avr_pkg::reg_addr_t'(f[2]);
                rec.wb_value = avr_pkg::data_t'(f[3]);
                rec.flags    = avr_pkg::flags_t'(f[4][3:0]);
                rec.next_pc  = avr_pkg::pc_t'(f[5]);
                expect_q.push_back(rec);
            end
        end
        $fclose(stim_fd);
    endtask

    task automatic check_pc(input string name, input avr_pkg::pc_t expected,
                            input avr_pkg::pc_t actual);
        if (expected !== actual)
        begin
            $display("ERROR %s: expected %h, actual %h", name, expected, actual);
            abort_run();
        end
    endtask

    task automatic check_data(input string name, input avr_pkg::data_t expected,
                              input avr_pkg::data_t actual);
        if (expected !== actual)
        begin
            $display("ERROR %s: expected %h, actual %h", name, expected, actual);
            abort_run();
        end
    endtask

    task automatic check_flags(input string name, input avr_pkg::flags_t expected,
                               input avr_pkg::flags_t actual);
        if (expected !== actual)
        begin
            $display("ERROR %s: expected zncv %b, actual zncv %b", name,
                     {expected.z, expected.n, expected.c, expected.v},
                     {actual.z, actual.n, actual.c, actual.v});
            abort_run();
        end
    endtask

    task automatic check_reg(input string name, input avr_pkg::reg_addr_t expected,
                             input avr_pkg::reg_addr_t actual);
        if (expected !== actual)
        begin
            $display("ERROR %s: expected r%0d, actual r%0d", name, expected, actual);
            abort_run();
        end
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        if (expected !== actual)
        begin
            $display("ERROR %s: expected %b, actual %b", name, expected, actual);
            abort_run();
        end
    endtask

    task automatic check_gap(input string name, input int expected, input int actual);
        if (expected != actual)
        begin
            $display("ERROR %s: expected %0d cycles, actual %0d cycles", name,
                     expected, actual);
            abort_run();
        end
    endtask

    // counts falling edges up to and including the one that sees retire_valid
    task automatic wait_retire(output int cycles);
        bit found;
        cycles = 0;
        found = 1'b0;
        while (!found && cycles < RETIRE_TIMEOUT)
        begin
            @(negedge clk);
            cycles++;
            found = retire_valid;
        end
        if (!found)
        begin
            $display("retire_valid did not pulse within %0d cycles", RETIRE_TIMEOUT);
            abort_run();
        end
    endtask

    initial
    begin
        int              gap;
        string           name;
        avr_pkg::trace_t exp_rec;
        rst_n = 1'b0;
        run = 1'b0;
        prog_we = 1'b0;
        prog_addr = '0;
        prog_data = '0;
        load_stimulus();
        if (expect_q.size() == 0)
        begin
            $display("stimulus file holds no expected trace records");
            abort_run();
        end
        repeat (8) @(posedge clk);
        #1;
        rst_n = 1'b1;
        foreach (program_q[i])
        begin
            @(posedge clk);
            #1;
            prog_we = 1'b1;
            prog_addr = avr_pkg::pc_t'(i);
            prog_data = program_q[i];
        end
        @(posedge clk);
        #1;
        prog_we = 1'b0;
        check_bit("idle retire_valid", 1'b0, retire_valid);
        @(posedge clk);
        #1;
        run = 1'b1;
        foreach (expect_q[i])
        begin
            exp_rec = expect_q[i];
            name = $sformatf("retire %0d", i);
            wait_retire(gap);
            check_gap({name, " spacing"}, `AVR_STAGE_COUNT, gap);
            check_pc({name, " pc"}, exp_rec.pc, retire_trace.pc);
            check_bit({name, " wb_en"}, exp_rec.wb_en, retire_trace.wb_en);
            // rd and value only mean something on a register write
            if (exp_rec.wb_en)
            begin
                check_reg({name, " rd"}, exp_rec.rd, retire_trace.rd);
                check_data({name, " value"}, exp_rec.wb_value, retire_trace.wb_value);
            end
            check_flags({name, " flags"}, exp_rec.flags, retire_trace.flags);
            check_pc({name, " next_pc"}, exp_rec.next_pc, retire_trace.next_pc);
        end
        $display("*** PASSED ***");
        $finish;
    end

endmodule

/* verilog/alu.sv */
`timescale 1ns/1ps

module alu (
    input  avr_pkg::alu_op_e op,
    input  avr_pkg::data_t   a,
    input  avr_pkg::data_t   b,
    output avr_pkg::data_t   result,
    output avr_pkg::flags_t  flags,
    output logic             carry_valid
);

    // ninth bit holds carry out or borrow
    logic [8:0] wide;

    always_comb
    begin
        wide        = {1'b0, b};
        flags.v     = 1'b0;
        carry_valid = 1'b0;
        case (op)
            avr_pkg::ALU_ADD:
            begin
                wide        = {1'b0, a} + {1'b0, b};
                carry_valid = 1'b1;
                flags.v     = (a[7] & b[7] & ~wide[7]) | (~a[7] & ~b[7] & wide[7]);
            end
            avr_pkg::ALU_SUB:
            begin
                wide        = {1'b0, a} - {1'b0, b};
                carry_valid = 1'b1;
                flags.v     = (a[7] & ~b[7] & ~wide[7]) | (~a[7] & b[7] & wide[7]);
            end
            avr_pkg::ALU_AND:
                wide = {1'b0, a & b};
            avr_pkg::ALU_EOR:
                wide = {1'b0, a ^ b};
            default:
                wide = {1'b0, b};
        endcase
        result  = wide[7:0];
        flags.z = (wide[7:0] == 8'h00);
        flags.n = wide[7];
        // only meaningful when carry_valid is high
        flags.c = wide[8];
    end

endmodule

/* verilog/avr_core.sv */
`timescale 1ns/1ps

module avr_core (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            run,
    input  logic            prog_we,
    input  avr_pkg::pc_t    prog_addr,
    input  avr_pkg::instr_t prog_data,
    output logic            retire_valid,
    output avr_pkg::trace_t retire_trace
);

    avr_pkg::pc_t       fetch_addr;
    avr_pkg::instr_t    instr;

    avr_pkg::reg_addr_t rd_addr;
    avr_pkg::reg_addr_t rr_addr;
    avr_pkg::data_t     rd_data;
    avr_pkg::data_t     rr_data;
    logic               wr_en;
    avr_pkg::reg_addr_t wr_addr;
    avr_pkg::data_t     wr_data;

    avr_pkg::alu_op_e   alu_op;
    avr_pkg::data_t     alu_a;
    avr_pkg::data_t     alu_b;
    avr_pkg::data_t     alu_result;
    avr_pkg::flags_t    alu_flags;
    logic               alu_carry_valid;

    logic               push;
    logic               pop;
    avr_pkg::pc_t       push_data;
    avr_pkg::pc_t       top_data;

    program_memory program_memory_inst (
        .clk     (clk),
        .we      (prog_we),
        .wr_addr (prog_addr),
        .wr_data (prog_data),
        .rd_addr (fetch_addr),
        .rd_data (instr)
    );

    control_unit control_unit_inst (
        .clk             (clk),
        .rst_n           (rst_n),
        .run             (run),
        .fetch_addr      (fetch_addr),
        .instr           (instr),
        .rd_addr         (rd_addr),
        .rr_addr         (rr_addr),
        .rd_data         (rd_data),
        .rr_data         (rr_data),
        .wr_en           (wr_en),
        .wr_addr         (wr_addr),
        .wr_data         (wr_data),
        .alu_op          (alu_op),
        .alu_a           (alu_a),
        .alu_b           (alu_b),
        .alu_result      (alu_result),
        .alu_flags       (alu_flags),
        .alu_carry_valid (alu_carry_valid),
        .push            (push),
        .pop             (pop),
        .push_data       (push_data),
        .top_data        (top_data),
        .retire_valid    (retire_valid),
        .retire_trace    (retire_trace)
    );

    register_file register_file_inst (
        .clk     (clk),
        .rst_n   (rst_n),
        .rd_addr (rd_addr),
        .rr_addr (rr_addr),
        .rd_data (rd_data),
        .rr_data (rr_data),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data)
    );

    alu alu_inst (
        .op          (alu_op),
        .a           (alu_a),
        .b           (alu_b),
        .result      (alu_result),
        .flags       (alu_flags),
        .carry_valid (alu_carry_valid)
    );

    // underflow is guarded inside the stack itself
    return_stack return_stack_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (push),
        .pop       (pop),
        .push_data (push_data),
        .top_data  (top_data),
        .empty     ()
    );

endmodule

/* verilog/avr_macros.svh */
`ifndef AVR_MACROS_SVH
`define AVR_MACROS_SVH

// datapath widths
`define AVR_PC_WIDTH       10
`define AVR_INSTR_WIDTH    16
`define AVR_DATA_WIDTH     8
`define AVR_REG_ADDR_WIDTH 5

// core geometry
`define AVR_STACK_DEPTH    16
`define AVR_STAGE_COUNT    4

// casez patterns, ? marks operand bits
`define AVR_LDI   16'b1110_????_????_????
`define AVR_MOV   16'b0010_11??_????_????
`define AVR_ADD   16'b0000_11??_????_????
`define AVR_SUB   16'b0001_10??_????_????
`define AVR_AND   16'b0010_00??_????_????
`define AVR_EOR   16'b0010_01??_????_????
`define AVR_RJMP  16'b1100_????_????_????
`define AVR_RCALL 16'b1101_????_????_????
`define AVR_RET   16'b1001_0101_0000_1000

`endif

/* verilog/avr_pkg.sv */
`include "avr_macros.svh"

package avr_pkg;

    typedef logic [`AVR_INSTR_WIDTH-1:0]    instr_t;
    typedef logic [`AVR_PC_WIDTH-1:0]       pc_t;
    typedef logic [`AVR_DATA_WIDTH-1:0]     data_t;
    typedef logic [`AVR_REG_ADDR_WIDTH-1:0] reg_addr_t;

    // one instruction walks all four stages
    typedef enum logic [$clog2(`AVR_STAGE_COUNT)-1:0] {
        STAGE_IF,
        STAGE_ID,
        STAGE_EX,
        STAGE_WB
    } stage_e;

    typedef enum logic [2:0] {
        ALU_PASS,
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_EOR
    } alu_op_e;

    typedef struct packed {
        logic z;
        logic n;
        logic c;
        logic v;
    } flags_t;

    typedef struct packed {
        alu_op_e   alu_op;
        reg_addr_t rd;
        reg_addr_t rr;
        data_t     immediate;
        logic      use_imm;
        logic      wb_en;
        logic      is_jump;
        logic      is_call;
        logic      is_ret;
        // signed word offset for rjmp and rcall
        logic [11:0] offset;
    } decoded_t;

    typedef struct packed {
        pc_t       pc;
        reg_addr_t rd;
        logic      wb_en;
        data_t     wb_value;
        flags_t    flags;
        pc_t       next_pc;
    } trace_t;

endpackage

/* verilog/control_unit.sv */
`timescale 1ns/1ps
`include "avr_macros.svh"

module control_unit (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               run,
    output avr_pkg::pc_t       fetch_addr,
    input  avr_pkg::instr_t    instr,
    output avr_pkg::reg_addr_t rd_addr,
    output avr_pkg::reg_addr_t rr_addr,
    input  avr_pkg::data_t     rd_data,
    input  avr_pkg::data_t     rr_data,
    output logic               wr_en,
    output avr_pkg::reg_addr_t wr_addr,
    output avr_pkg::data_t     wr_data,
    output avr_pkg::alu_op_e   alu_op,
    output avr_pkg::data_t     alu_a,
    output avr_pkg::data_t     alu_b,
    input  avr_pkg::data_t     alu_result,
    input  avr_pkg::flags_t    alu_flags,
    input  logic               alu_carry_valid,
    output logic               push,
    output logic               pop,
    output avr_pkg::pc_t       push_data,
    input  avr_pkg::pc_t       top_data,
    output logic               retire_valid,
    output avr_pkg::trace_t    retire_trace
);

    avr_pkg::stage_e   stage;
    avr_pkg::pc_t      pc;
    avr_pkg::flags_t   status;
    avr_pkg::decoded_t dec;

    // results held from EX until commit in WB
    avr_pkg::data_t    ex_result;
    avr_pkg::flags_t   ex_flags;
    avr_pkg::pc_t      ex_next_pc;

    avr_pkg::flags_t   new_flags;
    avr_pkg::pc_t      pc_plus_one;
    avr_pkg::pc_t      jump_target;
    avr_pkg::pc_t      next_pc;

    function automatic avr_pkg::decoded_t decode(input avr_pkg::instr_t ins);
        avr_pkg::decoded_t d;
        d           = '0;
        d.alu_op    = avr_pkg::ALU_PASS;
        d.rd        = ins[8:4];
        d.rr        = {ins[9], ins[3:0]};
        d.immediate = {ins[11:8], ins[3:0]};
        d.offset    = ins[11:0];
        casez (ins)
            `AVR_LDI:
            begin
                // ldi only reaches the upper sixteen registers
                d.rd      = {1'b1, ins[7:4]};
                d.use_imm = 1'b1;
                d.wb_en   = 1'b1;
            end
            `AVR_MOV:
                d.wb_en = 1'b1;
            `AVR_ADD:
            begin
                d.alu_op = avr_pkg::ALU_ADD;
                d.wb_en  = 1'b1;
            end
            `AVR_SUB:
            begin
                d.alu_op = avr_pkg::ALU_SUB;
                d.wb_en  = 1'b1;
            end
            `AVR_AND:
            begin
                d.alu_op = avr_pkg::ALU_AND;
                d.wb_en  = 1'b1;
            end
            `AVR_EOR:
            begin
                d.alu_op = avr_pkg::ALU_EOR;
                d.wb_en  = 1'b1;
            end
            `AVR_RJMP:
                d.is_jump = 1'b1;
            `AVR_RCALL:
                d.is_call = 1'b1;
            `AVR_RET:
                d.is_ret = 1'b1;
            default:
                d.wb_en = 1'b0;
        endcase
        return d;
    endfunction

    assign fetch_addr = pc;

    // operands read in EX from the latched decode
    assign rd_addr = dec.rd;
    assign rr_addr = dec.rr;
    assign alu_op  = dec.alu_op;
    assign alu_a   = rd_data;
    assign alu_b   = dec.use_imm ? dec.immediate : rr_data;

    assign pc_plus_one = pc + 1'b1;
    assign jump_target = pc_plus_one + dec.offset[`AVR_PC_WIDTH-1:0];

    always_comb
    begin
        if (dec.is_ret)
            next_pc = top_data;
        else if (dec.is_jump || dec.is_call)
            next_pc = jump_target;
        else
            next_pc = pc_plus_one;
    end

    // pass ops leave flags alone, logic ops keep the old carry
    always_comb
    begin
        new_flags = status;
        if (dec.alu_op != avr_pkg::ALU_PASS)
        begin
            new_flags.z = alu_flags.z;
            new_flags.n = alu_flags.n;
            new_flags.v = alu_flags.v;
            if (alu_carry_valid)
                new_flags.c = alu_flags.c;
        end
    end

    assign push      = (stage == avr_pkg::STAGE_EX) && dec.is_call;
    assign pop       = (stage == avr_pkg::STAGE_EX) && dec.is_ret;
    assign push_data = pc_plus_one;

    assign wr_en   = (stage == avr_pkg::STAGE_WB) && dec.wb_en;
    assign wr_addr = dec.rd;
    assign wr_data = ex_result;

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            stage  <= avr_pkg::STAGE_IF;
            pc     <= '0;
            status <= '0;
        end
        else
        begin
            case (stage)
                avr_pkg::STAGE_IF:
                    if (run)
                        stage <= avr_pkg::STAGE_ID;
                avr_pkg::STAGE_ID:
                    stage <= avr_pkg::STAGE_EX;
                avr_pkg::STAGE_EX:
                    stage <= avr_pkg::STAGE_WB;
                default:
                begin
                    stage  <= avr_pkg::STAGE_IF;
                    pc     <= ex_next_pc;
                    status <= ex_flags;
                end
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (stage == avr_pkg::STAGE_ID)
            dec <= decode(instr);
        if (stage == avr_pkg::STAGE_EX)
        begin
            ex_result  <= alu_result;
            ex_flags   <= new_flags;
            ex_next_pc <= next_pc;
        end
    end

    // trace is live for the single WB cycle
    assign retire_valid = (stage == avr_pkg::STAGE_WB);

    always_comb
    begin
        retire_trace.pc       = pc;
        retire_trace.rd       = dec.rd;
        retire_trace.wb_en    = dec.wb_en;
        retire_trace.wb_value = ex_result;
        retire_trace.flags    = ex_flags;
        retire_trace.next_pc  = ex_next_pc;
    end

endmodule

/* verilog/program_memory.sv */
`timescale 1ns/1ps
`include "avr_macros.svh"

module program_memory (
    input  logic            clk,
    input  logic            we,
    input  avr_pkg::pc_t    wr_addr,
    input  avr_pkg::instr_t wr_data,
    input  avr_pkg::pc_t    rd_addr,
    output avr_pkg::instr_t rd_data
);

    localparam int DEPTH = 1 << `AVR_PC_WIDTH;

    avr_pkg::instr_t mem [DEPTH];

    // loader writes only while the core is idle, so no port conflict
    always_ff @(posedge clk)
    begin
        if (we)
            mem[wr_addr] <= wr_data;
    end

    // registered fetch, word shows up one cycle after the address
    always_ff @(posedge clk)
    begin
        rd_data <= mem[rd_addr];
    end

endmodule

/* verilog/register_file.sv */
`timescale 1ns/1ps
`include "avr_macros.svh"

module register_file (
    input  logic               clk,
    input  logic               rst_n,
    input  avr_pkg::reg_addr_t rd_addr,
    input  avr_pkg::reg_addr_t rr_addr,
    output avr_pkg::data_t     rd_data,
    output avr_pkg::data_t     rr_data,
    input  logic               wr_en,
    input  avr_pkg::reg_addr_t wr_addr,
    input  avr_pkg::data_t     wr_data
);

    localparam int NUM_REGS = 1 << `AVR_REG_ADDR_WIDTH;

    avr_pkg::data_t regs [NUM_REGS];

    // combinational read ports
    assign rd_data = regs[rd_addr];
    assign rr_data = regs[rr_addr];

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i < NUM_REGS; i++)
                regs[i] <= '0;
        end
        else if (wr_en)
        begin
            regs[wr_addr] <= wr_data;
        end
    end

endmodule

/* verilog/return_stack.sv */
`timescale 1ns/1ps
`include "avr_macros.svh"

module return_stack (
    input  logic         clk,
    input  logic         rst_n,
    input  logic         push,
    input  logic         pop,
    input  avr_pkg::pc_t push_data,
    output avr_pkg::pc_t top_data,
    output logic         empty
);

    localparam int DEPTH = `AVR_STACK_DEPTH;
    localparam int IDX_W = $clog2(DEPTH);

    avr_pkg::pc_t stack [DEPTH];

    // entry count, one wider than the index
    logic [IDX_W:0] ptr;
    logic [IDX_W:0] top_idx;
    logic           full;

    assign top_idx  = ptr - 1'b1;
    assign empty    = (ptr == '0);
    assign full     = (ptr == (IDX_W + 1)'(DEPTH));
    assign top_data = empty ? '0 : stack[top_idx[IDX_W-1:0]];

    always_ff @(posedge clk)
    begin
        if (push && !full)
            stack[ptr[IDX_W-1:0]] <= push_data;
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
            ptr <= '0;
        else if (push && !full)
            ptr <= ptr + 1'b1;
        else if (pop && !empty)
            ptr <= ptr - 1'b1;
    end

endmodule
